// ==== spi_flash_lite.f ====
verilog/spi_cfg_pkg.sv
verilog/spi_cmd_pkg.sv
verilog/spi_host_byte.sv
verilog/spi_txn_sequencer.sv
verilog/spi_flash_lite.sv
dv/spi_flash_lite_assertions.sv
dv/spi_flash_lite_tb.sv

// ==== Makefile ====
TOP  := spi_flash_lite_tb
SRCS := $(shell grep -v '^+' spi_flash_lite.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q '^PASS: all tests$$' sim.log

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): $(SRCS) spi_flash_lite.f
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f spi_flash_lite.f

clean:
	rm -rf obj_dir sim.log

// ==== dv/spi_flash_lite_tb.sv ====
module spi_flash_lite_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import spi_cfg_pkg::*;
	import spi_cmd_pkg::*;

	localparam int NUM_TXN      = 10;
	localparam int RESET_CYCLES = 16;

	logic       clk;
	logic       rst_n = 1'b0;
	spi_cfg_t   cfg = '0;
	logic       start = 1'b0;
	spi_req_t   req = '0;
	logic       busy;
	logic       done;
	spi_rsp_t   rsp;
	logic       spi_cs_n;
	logic       spi_sck;
	logic       spi_mosi;
	logic       spi_miso = 1'b0;

	// Test table, filled once before reset ends
	spi_req_t    txn_req [NUM_TXN];
	logic [15:0] txn_div [NUM_TXN];
	string       txn_name [NUM_TXN];
	bit          txn_busy_start [NUM_TXN];
	int          seed;
	int          total_cycles = 0;
	int          check_count = 0;
	int          err_count = 0;
	int          done_count = 0;

	// Device model state
	logic [7:0] rx_bytes[$];
	logic [7:0] dev_tx = '0;
	logic [7:0] dev_rx = '0;
	logic [7:0] dev_last = '0;
	int         dev_bit = 0;
	bit         dev_byte_done = 1'b0;
	logic       cs_prev = 1'b1;
	logic       sck_prev = 1'b0;

	spi_flash_lite #(
		.SAMPLE_EDGE (edge_rising)
	) spi_flash_lite_i (.*);

	bind spi_flash_lite spi_flash_lite_assertions spi_flash_lite_assertions_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg      (cfg),
		.start    (start),
		.busy     (busy),
		.done     (done),
		.spi_cs_n (spi_cs_n),
		.spi_sck  (spi_sck)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// SPI device model

	// Samples MOSI on rising SCK, drives MISO on falling SCK
	always @(spi_cs_n or spi_sck) begin
		if (cs_prev && !spi_cs_n) begin
			// New transaction, first reply is fixed
			rx_bytes.delete();
			dev_tx        = 8'hA5;
			dev_bit       = 0;
			dev_byte_done = 1'b0;
			spi_miso      = dev_tx[7];
		end else if (!spi_cs_n && spi_sck && !sck_prev) begin
			dev_rx = {dev_rx[6:0], spi_mosi};
			if (dev_bit == 7) begin
				rx_bytes.push_back(dev_rx);
				dev_last      = dev_rx;
				dev_byte_done = 1'b1;
				dev_bit       = 0;
			end else begin
				dev_bit = dev_bit + 1;
			end
		end else if (!spi_cs_n && !spi_sck && sck_prev) begin
			// Next reply is the byte just received XOR A5
			if (dev_byte_done) begin
				dev_tx        = dev_last ^ 8'hA5;
				dev_byte_done = 1'b0;
			end else begin
				dev_tx = {dev_tx[6:0], 1'b0};
			end
			spi_miso = dev_tx[7];
		end
		cs_prev  = spi_cs_n;
		sck_prev = spi_sck;
	end

	always @(posedge clk) begin
		if (rst_n && done)
			done_count <= done_count + 1;
	end

	//////////////////////////////
	// Helpers

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	// Cycles per byte follow the 18 half period rule plus handshake
	function automatic int txn_cycles(input spi_req_t r, input logic [15:0] div);
		int nbytes;
		nbytes = (r.long_header ? 4 : 1) + int'(r.data_len);
		return nbytes * (18 * (int'(div[15:1]) + 1) + 2) + 10;
	endfunction

	task automatic build_tests();
		spi_req_t    r;
		logic [31:0] w;
		int          i;
		int          sum;
		seed = 32'h66d4d328;
		sum  = 0;
		for (i = 0; i < NUM_TXN; i++) begin
			w = rand_word();
			r.header.fields.opcode = w[31:24];
			r.header.fields.addr   = w[23:0];
			r.wdata                = rand_word();
			w = rand_word();
			r.long_header     = w[0];
			r.data_len        = 3'(w[15:8] % 8'd5);
			txn_div[i]        = 16'd2;
			txn_busy_start[i] = 1'b0;
			if (i == 0) begin
				txn_name[i]   = "short_read";
				r.long_header = 1'b0;
				r.data_len    = 3'd4;
			end else if (i <= 3) begin
				txn_name[i]   = "long_header";
				r.long_header = 1'b1;
			end else if (i == 4) begin
				txn_name[i]       = "busy_start";
				txn_busy_start[i] = 1'b1;
				// Data bytes leave after the second start and show any takeover
				r.data_len        = 3'd4;
			end else if (i == 5) begin
				txn_name[i]   = "slow_clk";
				r.long_header = 1'b0;
				r.data_len    = 3'd4;
				txn_div[i]    = 16'd8;
			end else begin
				txn_name[i] = "random";
				txn_div[i]  = 16'(2 + 2 * (w[23:16] % 8'd3));
			end
			txn_req[i] = r;
			sum = sum + txn_cycles(r, txn_div[i]);
		end
		total_cycles = sum;
	endtask

	task automatic check_value(input string test, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("** Error %s: %s expected %h, actual %h", test, what, exp, act);
		end
	endtask

	task automatic run_txn(input int idx);
		spi_req_t    r;
		spi_req_t    other;
		logic [7:0]  exp_tx[$];
		logic [31:0] exp_rdata;
		int          hdr_len;
		int          dones_before;
		int          i;
		r       = txn_req[idx];
		hdr_len = r.long_header ? 4 : 1;
		// Wire order: opcode, address high to low, write data high to low
		exp_tx.push_back(r.header.fields.opcode);
		if (r.long_header) begin
			exp_tx.push_back(r.header.fields.addr[23:16]);
			exp_tx.push_back(r.header.fields.addr[15:8]);
			exp_tx.push_back(r.header.fields.addr[7:0]);
		end
		for (i = 0; i < int'(r.data_len); i++)
			exp_tx.push_back(r.wdata[31 - 8 * i -: 8]);
		// Data phase replies, last one ends in the low byte
		exp_rdata = '0;
		for (i = hdr_len; i < exp_tx.size(); i++)
			exp_rdata = {exp_rdata[23:0], exp_tx[i - 1] ^ 8'hA5};
		dones_before = done_count;
		@(posedge clk);
		#2;
		cfg.clkdiv = txn_div[idx];
		req        = r;
		start      = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		if (txn_busy_start[idx]) begin
			// A different request that must be dropped
			other                      = r;
			other.header.fields.opcode = ~r.header.fields.opcode;
			other.wdata                = ~r.wdata;
			repeat (3) @(posedge clk);
			#2;
			req   = other;
			start = 1'b1;
			@(posedge clk);
			#2;
			start = 1'b0;
		end
		@(negedge clk);
		while (!done)
			@(negedge clk);
		@(negedge clk);
		check_value(txn_name[idx], "done count", 32'(dones_before + 1), 32'(done_count));
		check_value(txn_name[idx], "byte count", 32'(exp_tx.size()), 32'(rx_bytes.size()));
		for (i = 0; i < exp_tx.size() && i < rx_bytes.size(); i++)
			check_value(txn_name[idx], $sformatf("byte %0d", i), 32'(exp_tx[i]),
				32'(rx_bytes[i]));
		check_value(txn_name[idx], "first_rx", 32'h0000_00a5, 32'(rsp.first_rx));
		check_value(txn_name[idx], "rdata", exp_rdata, rsp.rdata);
	endtask

	//////////////////////////////
	// Watchdog and main sequence

	initial begin
		wait (total_cycles != 0);
		repeat (RESET_CYCLES + 2 * total_cycles) @(posedge clk);
		$display("Timeout: transactions did not finish within %0d cycles", 2 * total_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int n;
		int proto_errors;
		build_tests();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// Idle stretch after reset before the first start
		repeat (8) @(posedge clk);
		for (n = 0; n < NUM_TXN; n++)
			run_txn(n);
		repeat (10) @(posedge clk);
		check_value("summary", "done pulses", 32'(NUM_TXN), 32'(done_count));
		proto_errors = spi_flash_lite_i.spi_flash_lite_assertions_i.fail_count;
		$display("Checks %0d, data errors %0d, assertion errors %0d",
			check_count, err_count, proto_errors);
		if (err_count == 0 && proto_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== dv/spi_flash_lite_assertions.sv ====
module spi_flash_lite_assertions (
	input logic                  clk,
	input logic                  rst_n,
	input spi_cfg_pkg::spi_cfg_t cfg,
	input logic                  start,
	input logic                  busy,
	input logic                  done,
	input logic                  spi_cs_n,
	input logic                  spi_sck
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failures seen so far, read by the testbench at the end
	int          fail_count = 0;
	logic        started;
	logic        sck_q;
	logic [15:0] ph_cnt;
	logic [2:0]  fall_cnt;
	logic [15:0] half;

	// Expected SCK phase length in system clocks
	assign half = {1'b0, cfg.clkdiv[15:1]} + 16'd1;

	//////////////////////////////
	// Phase tracking

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			started  <= 1'b0;
			sck_q    <= 1'b0;
			ph_cnt   <= '0;
			fall_cnt <= '0;
		end else begin
			if (start)
				started <= 1'b1;
			sck_q <= spi_sck;
			// Samples since SCK last changed
			if (spi_sck != sck_q)
				ph_cnt <= 16'd1;
			else
				ph_cnt <= ph_cnt + 16'd1;
			// Eight falls per byte, wraps at byte end
			if (sck_q && !spi_sck)
				fall_cnt <= fall_cnt + 3'd1;
		end
	end

	//////////////////////////////
	// Pin and strobe rules

	a_idle_until_start: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> spi_cs_n && !spi_sck && !busy && !done)
		else begin
			$error("Bus or strobes left idle state before the first start");
			fail_count = fail_count + 1;
		end

	a_sck_low_deselected: assert property (@(posedge clk) disable iff (!rst_n)
		spi_cs_n |-> !spi_sck)
		else begin
			$error("SCK high while chip select is released");
			fail_count = fail_count + 1;
		end

	a_done_after_deselect: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(spi_cs_n) |=> done)
		else begin
			$error("No done one cycle after chip select rose");
			fail_count = fail_count + 1;
		end

	// Only a fresh deselect may produce done
	a_done_source: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(spi_cs_n) && !$past(spi_cs_n, 2))
		else begin
			$error("Done without a chip select release just before it");
			fail_count = fail_count + 1;
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else begin
			$error("Done lasted longer than one cycle");
			fail_count = fail_count + 1;
		end

	a_start_accepted: assert property (@(posedge clk) disable iff (!rst_n)
		start && !busy |=> !spi_cs_n)
		else begin
			$error("Start while idle did not select the device");
			fail_count = fail_count + 1;
		end

	a_high_phase: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(spi_sck) |-> ph_cnt == half)
		else begin
			$error("SCK high phase has the wrong length");
			fail_count = fail_count + 1;
		end

	// First rise of a byte follows a longer gap
	a_low_phase: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(spi_sck) && fall_cnt != 3'd0 |-> ph_cnt == half)
		else begin
			$error("SCK low phase inside a byte has the wrong length");
			fail_count = fail_count + 1;
		end

endmodule

// ==== verilog/spi_flash_lite.sv ====
module spi_flash_lite #(
	parameter spi_cfg_pkg::spi_edge_e SAMPLE_EDGE = spi_cfg_pkg::edge_rising,
	parameter bit LOCAL_INVERTED = 1'b0,
	parameter bit CHANGE_ON_DONE = 1'b0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  spi_cfg_pkg::spi_cfg_t  cfg,
	input  logic                   start,
	input  spi_cmd_pkg::spi_req_t  req,
	output logic                   busy,
	output logic                   done,
	output spi_cmd_pkg::spi_rsp_t  rsp,
	output logic                   spi_cs_n,
	output logic                   spi_sck,
	output logic                   spi_mosi,
	input  logic                   spi_miso
);

	// Byte handshake between sequencer and transceiver
	logic       shift_en;
	logic       shift_done;
	logic [7:0] tx_byte;
	logic [7:0] rx_byte;

	// Owns chip select and the byte order
	spi_txn_sequencer spi_txn_sequencer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.req        (req),
		.shift_done (shift_done),
		.rx_byte    (rx_byte),
		.busy       (busy),
		.done       (done),
		.rsp        (rsp),
		.shift_en   (shift_en),
		.tx_byte    (tx_byte),
		.spi_cs_n   (spi_cs_n)
	);

	// SCK generation and bit shifting
	spi_host_byte #(
		.SAMPLE_EDGE    (SAMPLE_EDGE),
		.LOCAL_INVERTED (LOCAL_INVERTED),
		.CHANGE_ON_DONE (CHANGE_ON_DONE)
	) spi_host_byte_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.shift_en   (shift_en),
		.tx_byte    (tx_byte),
		.spi_miso   (spi_miso),
		.shift_done (shift_done),
		.rx_byte    (rx_byte),
		.spi_sck    (spi_sck),
		.spi_mosi   (spi_mosi)
	);

endmodule

// ==== verilog/spi_txn_sequencer.sv ====
module spi_txn_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  spi_cmd_pkg::spi_req_t  req,
	input  logic                   shift_done,
	input  logic [7:0]             rx_byte,
	output logic                   busy,
	output logic                   done,
	output spi_cmd_pkg::spi_rsp_t  rsp,
	output logic                   shift_en,
	output logic [7:0]             tx_byte,
	output logic                   spi_cs_n
);
	import spi_cmd_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SELECT,
		ST_HEADER,
		ST_DATA,
		ST_DESELECT,
		ST_REPORT
	} state_e;

	state_e     state;
	spi_req_t   req_q;
	logic       accept;
	logic       hdr_step;
	logic       data_step;
	logic [1:0] hdr_sel;
	logic [1:0] hdr_next;
	logic       hdr_last;
	logic [2:0] data_cnt;
	logic [2:0] data_next;
	logic       data_last;

	//////////////////////////////
	// Byte bookkeeping

	assign accept    = (state == ST_IDLE) && start;
	assign hdr_step  = (state == ST_HEADER) && shift_done;
	assign data_step = (state == ST_DATA) && shift_done;

	// Header bytes count down from byte 3
	assign hdr_next = hdr_sel - 2'd1;
	assign hdr_last = !req_q.long_header || (hdr_sel == 2'd0);

	// Data bytes count up to data_len, never past four
	assign data_next = data_cnt + 3'd1;
	assign data_last = (data_next >= req_q.data_len) || data_next[2];

	// Starts are ignored for the whole transaction including the done cycle
	assign busy = (state != ST_IDLE);
	assign done = (state == ST_REPORT);

	//////////////////////////////
	// Transaction FSM

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			shift_en <= 1'b0;
			spi_cs_n <= 1'b1;
			hdr_sel  <= 2'd3;
			data_cnt <= '0;
		end else begin
			shift_en <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state    <= ST_SELECT;
						spi_cs_n <= 1'b0;
					end
				end
				// One cycle of setup after chip select falls
				ST_SELECT: begin
					state    <= ST_HEADER;
					shift_en <= 1'b1;
					hdr_sel  <= 2'd3;
				end
				ST_HEADER: begin
					if (shift_done) begin
						if (!hdr_last) begin
							hdr_sel  <= hdr_next;
							shift_en <= 1'b1;
						end else if (req_q.data_len != 3'd0) begin
							state    <= ST_DATA;
							data_cnt <= '0;
							shift_en <= 1'b1;
						end else begin
							state    <= ST_DESELECT;
							spi_cs_n <= 1'b1;
						end
					end
				end
				ST_DATA: begin
					if (shift_done) begin
						if (!data_last) begin
							data_cnt <= data_next;
							shift_en <= 1'b1;
						end else begin
							state    <= ST_DESELECT;
							spi_cs_n <= 1'b1;
						end
					end
				end
				// Chip select is already high here
				ST_DESELECT: state <= ST_REPORT;
				ST_REPORT:   state <= ST_IDLE;
				default:     state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Request and reply data

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q     <= req;
			rsp.rdata <= '0;
		end
		if (state == ST_SELECT)
			tx_byte <= req_q.header.bytes[3];
		if (hdr_step) begin
			// Reply to the opcode byte
			if (hdr_sel == 2'd3)
				rsp.first_rx <= rx_byte;
			if (!hdr_last)
				tx_byte <= req_q.header.bytes[hdr_next];
			else
				tx_byte <= req_q.wdata[31:24];
		end
		if (data_step) begin
			rsp.rdata <= {rsp.rdata[23:0], rx_byte};
			// Inverted index picks bytes MSB first
			tx_byte   <= req_q.wdata[{~data_next[1:0], 3'b000} +: 8];
		end
	end

endmodule

// ==== verilog/spi_host_byte.sv ====
module spi_host_byte #(
	// SCK edge the remote device samples on
	parameter spi_cfg_pkg::spi_edge_e SAMPLE_EDGE = spi_cfg_pkg::edge_rising,
	// Sample MISO on the device sample edge instead of the opposite one
	parameter bit LOCAL_INVERTED = 1'b0,
	// Hold rx_byte stable until shift_done, one extra cycle of latency
	parameter bit CHANGE_ON_DONE = 1'b0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  spi_cfg_pkg::spi_cfg_t  cfg,
	input  logic                   shift_en,
	input  logic [7:0]             tx_byte,
	input  logic                   spi_miso,
	output logic                   shift_done,
	output logic [7:0]             rx_byte,
	output logic                   spi_sck,
	output logic                   spi_mosi
);
	import spi_cfg_pkg::*;

	// Edge directions resolved at elaboration
	localparam bit DEV_RISE   = (SAMPLE_EDGE == edge_rising);
	localparam bit LOCAL_RISE = (DEV_RISE == LOCAL_INVERTED);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CLOCK,
		ST_TRAIL
	} state_e;

	state_e      state;
	logic [14:0] half_cnt;
	logic        toggle;
	logic [3:0]  edge_cnt;
	logic        rising;
	logic        launch;
	logic        capture;
	logic [6:0]  tx_shreg;
	logic [7:0]  rx_shreg;
	logic        done_adv;

	//////////////////////////////
	// Half period timing

	// Toggle once the counter reaches half the divider
	assign toggle = (state != ST_IDLE) && (half_cnt >= cfg.clkdiv[15:1]);

	// SCK low now means this toggle is a rising edge
	assign rising = !spi_sck;

	// Drive the next bit on the edge the device does not sample on
	// First rising edge in falling mode keeps the bit loaded at start
	assign launch = (rising != DEV_RISE) && (edge_cnt != 4'd0);

	// Local MISO sample point
	assign capture = (rising == LOCAL_RISE);

	//////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			half_cnt <= '0;
			edge_cnt <= '0;
			spi_sck  <= 1'b0;
			spi_mosi <= 1'b0;
			done_adv <= 1'b0;
		end else begin
			done_adv <= 1'b0;
			if (shift_en) begin
				// New byte, MSB is on the wire right away
				state    <= ST_CLOCK;
				half_cnt <= '0;
				edge_cnt <= '0;
				spi_sck  <= 1'b0;
				spi_mosi <= tx_byte[7];
			end else if (toggle) begin
				half_cnt <= '0;
				edge_cnt <= edge_cnt + 4'd1;
				if (state == ST_CLOCK) begin
					spi_sck <= !spi_sck;
					if (launch)
						spi_mosi <= tx_shreg[6];
					// Sixteen edges done, counter wraps to zero
					if (edge_cnt == 4'd15)
						state <= ST_TRAIL;
				end else begin
					// SCK stays low through the last low phase and a trailing half
					if (edge_cnt == 4'd1) begin
						state    <= ST_IDLE;
						done_adv <= 1'b1;
					end
				end
			end else if (state != ST_IDLE) begin
				half_cnt <= half_cnt + 15'd1;
			end
		end
	end

	//////////////////////////////
	// Shift registers

	always_ff @(posedge clk) begin
		if (shift_en) begin
			tx_shreg <= tx_byte[6:0];
		end else if (toggle && (state == ST_CLOCK)) begin
			if (launch)
				tx_shreg <= {tx_shreg[5:0], 1'b0};
			// MSB first in
			if (capture)
				rx_shreg <= {rx_shreg[6:0], spi_miso};
		end
	end

	// Output stage
	if (CHANGE_ON_DONE) begin : g_hold
		logic [7:0] rx_hold;
		logic       done_q;

		always_ff @(posedge clk) begin
			if (!rst_n)
				done_q <= 1'b0;
			else
				done_q <= done_adv;
		end

		always_ff @(posedge clk) begin
			if (done_adv)
				rx_hold <= rx_shreg;
		end

		assign shift_done = done_q;
		assign rx_byte    = rx_hold;
	end else begin : g_direct
		// Shift register shows through while bits arrive
		assign shift_done = done_adv;
		assign rx_byte    = rx_shreg;
	end

endmodule

// ==== verilog/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

	//////////////////////////////
	// Transaction header

	// Command view of the header word
	typedef struct packed {
		logic [7:0]  opcode;
		logic [23:0] addr;
	} spi_hdr_fields_t;

	// Same 32 bits seen as bytes for shifting
	// Byte 3 holds the opcode and goes out first
	typedef union packed {
		spi_hdr_fields_t  fields;
		logic [3:0][7:0]  bytes;
	} spi_header_u;

	//////////////////////////////
	// Request and response

	// One transaction as issued by the user
	typedef struct packed {
		spi_header_u header;
		// Send all four header bytes, otherwise the opcode only
		logic        long_header;
		// Number of data bytes, 0 to 4
		logic [2:0]  data_len;
		// Write data, MSB first on the wire
		logic [31:0] wdata;
	} spi_req_t;

	// Bytes collected during the transaction
	typedef struct packed {
		// Data phase replies, last byte in the low byte
		logic [31:0] rdata;
		// Reply seen while the opcode was shifted
		logic [7:0]  first_rx;
	} spi_rsp_t;

endpackage

// ==== verilog/spi_cfg_pkg.sv ====
package spi_cfg_pkg;

	//////////////////////////////
	// Link configuration

	// SCK edge on which the remote device samples MOSI
	typedef enum logic {
		edge_rising  = 1'b0,
		edge_falling = 1'b1
	} spi_edge_e;

	// Runtime configuration word
	// Zero based divider with the LSB ignored and a minimum of 2
	// One SCK half period lasts clkdiv/2 + 1 system clocks
	typedef struct packed {
		logic [15:0] clkdiv;
	} spi_cfg_t;

endpackage
